// File: cdma_top.f
+incdir+include
hdl/cdma_pkg.sv
hdl/req_queue.sv
hdl/dma_rd_engine.sv
hdl/dma_wr_engine.sv
hdl/mem_arbiter.sv
hdl/burst_mem.sv
hdl/cdma_top.sv
dv/tb_clock.sv
dv/cdma_asserts.sv
dv/cdma_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the DMA testbench with Verilator and runs it.
# The exit status is nonzero when the build or the simulation fails.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f cdma_top.f --top-module cdma_tb -o cdma_sim &&
./obj_dir/cdma_sim &&
echo "run_sim: simulation finished with status 0" ||
{ echo "run_sim: build or simulation failed"; exit 1; }

// File: dv/cdma_tb.sv
// DMA testbench with random requests, memory and stream model, checks and timeout
`timescale 1ns/10ps
`include "cdma_params.svh"

module cdma_tb;

  localparam int N_PAIR = 12;
  localparam int N_LONG = 3;
  localparam int N_CONC = 6;
  localparam int N_FULL = 5;
  // Region A for reads, region B for concurrent writes
  localparam int REGION = `CDMA_MEM_WORDS / 2;

  logic                       aclk;
  logic                       rst_n;
  cdma_pkg::dma_req_t         rd_req;
  logic                       rd_req_valid;
  logic                       rd_req_ready;
  logic                       rd_done;
  cdma_pkg::dma_req_t         wr_req;
  logic                       wr_req_valid;
  logic                       wr_req_ready;
  logic                       wr_done;
  cdma_pkg::axis_t            m_axis;
  logic                       m_axis_valid;
  logic                       m_axis_ready;
  cdma_pkg::axis_t            s_axis;
  logic                       s_axis_valid;
  logic                       s_axis_ready;

  // Model state
  logic [`CDMA_DATA_BITS-1:0] model_mem [`CDMA_MEM_WORDS];
  logic [`CDMA_DATA_BITS-1:0] s_words [$];
  cdma_pkg::axis_t            exp_q [$];
  int                         wr_cum [$];
  int                         wr_words_total = 0;
  int                         s_count = 0;
  bit                         s_taken = 1'b0;
  int                         rd_last_seen = 0;
  int                         rd_done_cnt = 0;
  int                         wr_done_cnt = 0;
  int                         rd_issued = 0;
  int                         wr_issued = 0;
  bit                         hold_stream = 1'b0;
  int                         cycles = 0;
  int                         timeout_limit = 1000000;

  // Pre-drawn request ranges
  int a_addr [N_PAIR];
  int a_len  [N_PAIR];
  int b_addr [N_LONG];
  int b_len  [N_LONG];
  int c_addr [N_CONC];
  int c_len  [N_CONC];
  int d_addr [N_FULL];
  int d_len  [N_FULL];

  tb_clock u_tb_clock (.aclk(aclk));

  cdma_top u_cdma_top (
    .aclk(aclk), .rst_n(rst_n),
    .rd_req(rd_req), .rd_req_valid(rd_req_valid), .rd_req_ready(rd_req_ready),
    .rd_done(rd_done),
    .wr_req(wr_req), .wr_req_valid(wr_req_valid), .wr_req_ready(wr_req_ready),
    .wr_done(wr_done),
    .m_axis(m_axis), .m_axis_valid(m_axis_valid), .m_axis_ready(m_axis_ready),
    .s_axis(s_axis), .s_axis_valid(s_axis_valid), .s_axis_ready(s_axis_ready)
  );

  ////////////////////////////////////////////////////////////
  // Reporting and helpers
  ////////////////////////////////////////////////////////////

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_equal(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act) begin
      stop_run($sformatf("FAILED %s: expected 0x%08h, got 0x%08h", name, exp, act));
    end
  endtask

  function automatic int rand_len(input int lo, input int hi);
    return lo + int'($urandom % (hi - lo + 1));
  endfunction

  // Range kept inside its region, no wrap
  function automatic int rand_addr(input int base, input int len);
    return base + int'($urandom % (REGION - len + 1));
  endfunction

  // Random data into the model, then the request
  task automatic issue_write(input int addr, input int len);
    logic [`CDMA_DATA_BITS-1:0] word;
    for (int i = 0; i < len; i++) begin
      word = $urandom;
      model_mem[`CDMA_ADDR_BITS'(addr + i)] = word;
      s_words.push_back(word);
    end
    wr_words_total += len;
    wr_cum.push_back(wr_words_total);
    wr_issued++;
    @(posedge aclk);
    #2;
    wr_req.addr  = `CDMA_ADDR_BITS'(addr);
    wr_req.len   = `CDMA_LEN_BITS'(len);
    wr_req_valid = 1'b1;
    // Ready comes from queue state, settled here
    while (!wr_req_ready) begin
      @(posedge aclk);
      #2;
    end
    @(posedge aclk);
    #2;
    wr_req_valid = 1'b0;
  endtask

  // Expected words taken from the model
  task automatic issue_read(input int addr, input int len);
    cdma_pkg::axis_t exp;
    for (int i = 0; i < len; i++) begin
      exp.tdata = model_mem[`CDMA_ADDR_BITS'(addr + i)];
      exp.tlast = (i == len - 1);
      exp_q.push_back(exp);
    end
    rd_issued++;
    @(posedge aclk);
    #2;
    rd_req.addr  = `CDMA_ADDR_BITS'(addr);
    rd_req.len   = `CDMA_LEN_BITS'(len);
    rd_req_valid = 1'b1;
    while (!rd_req_ready) begin
      @(posedge aclk);
      #2;
    end
    @(posedge aclk);
    #2;
    rd_req_valid = 1'b0;
  endtask

  task automatic wait_writes_done();
    while (wr_done_cnt < wr_issued) @(posedge aclk);
  endtask

  task automatic wait_reads_done();
    while (rd_done_cnt < rd_issued) @(posedge aclk);
  endtask

  ////////////////////////////////////////////////////////////
  // Stream drivers
  ////////////////////////////////////////////////////////////

  always @(posedge aclk) begin
    #2;
    // Offered word held until taken
    if (!s_axis_valid || s_taken) begin
      if (s_words.size() > 0 && !hold_stream && ($urandom % 4 != 0)) begin
        s_axis.tdata = s_words[0];
        s_axis_valid = 1'b1;
      end else begin
        s_axis_valid = 1'b0;
      end
    end
    m_axis_ready = ($urandom % 3 != 0);
  end

  ////////////////////////////////////////////////////////////
  // Stream handshakes and done monitors
  ////////////////////////////////////////////////////////////

  // Falling edge view of the handshakes the next rising edge completes
  always @(negedge aclk) begin
    cdma_pkg::axis_t exp;
    s_taken = rst_n && s_axis_valid && s_axis_ready;
    if (s_taken) begin
      void'(s_words.pop_front());
      s_count++;
    end
    if (rst_n && m_axis_valid && m_axis_ready) begin
      if (exp_q.size() == 0) begin
        stop_run("Output stream gave a word that no read request asked for");
      end else begin
        exp = exp_q.pop_front();
        check_equal("m_axis.tdata", exp.tdata, m_axis.tdata);
        check_equal("m_axis.tlast", 32'(exp.tlast), 32'(m_axis.tlast));
        if (m_axis.tlast) begin
          rd_last_seen++;
        end
      end
    end
    if (rst_n && rd_done) begin
      rd_done_cnt++;
      if (rd_done_cnt > rd_last_seen) begin
        stop_run("rd_done pulsed before the last word of its read left m_axis");
      end
    end
    // Words taken so far must cover this request
    if (rst_n && wr_done) begin
      wr_done_cnt++;
      if (wr_done_cnt > wr_cum.size()) begin
        stop_run("wr_done pulsed with no write request outstanding");
      end else if (s_count < wr_cum[wr_done_cnt - 1]) begin
        stop_run("wr_done pulsed before the last word of its write was taken");
      end
    end
  end

  // Timeout
  always @(posedge aclk) begin
    cycles++;
    if (cycles > timeout_limit) begin
      stop_run("Timeout, the DMA did not finish its requests in time");
    end
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int total;
    void'($urandom(24829));
    rst_n        = 1'b0;
    rd_req       = '0;
    rd_req_valid = 1'b0;
    wr_req       = '0;
    wr_req_valid = 1'b0;
    m_axis_ready = 1'b0;
    s_axis       = '0;
    s_axis_valid = 1'b0;

    // Draw all ranges first so the limit follows the total words
    total = 0;
    for (int i = 0; i < N_PAIR; i++) begin
      a_len[i]  = rand_len(1, 40);
      a_addr[i] = rand_addr(0, a_len[i]);
      total    += 3 * a_len[i];
    end
    for (int i = 0; i < N_LONG; i++) begin
      b_len[i]  = rand_len(`CDMA_BURST_LEN + 1, 255);
      b_addr[i] = rand_addr(0, b_len[i]);
      total    += 2 * b_len[i];
    end
    for (int i = 0; i < N_CONC; i++) begin
      c_len[i]  = rand_len(1, 40);
      c_addr[i] = rand_addr(REGION, c_len[i]);
      total    += 2 * c_len[i];
    end
    for (int i = 0; i < N_FULL; i++) begin
      d_len[i]  = rand_len(1, 40);
      d_addr[i] = rand_addr(REGION, d_len[i]);
      total    += 2 * d_len[i];
    end
    timeout_limit = total * 8 + 2000;

    repeat (4) @(posedge aclk);
    #2;
    rst_n = 1'b1;

    // Short write then read back
    for (int i = 0; i < N_PAIR; i++) begin
      issue_write(a_addr[i], a_len[i]);
      wait_writes_done();
      issue_read(a_addr[i], a_len[i]);
      wait_reads_done();
    end

    // Long requests over burst boundaries
    for (int i = 0; i < N_LONG; i++) begin
      issue_write(b_addr[i], b_len[i]);
      wait_writes_done();
      issue_read(b_addr[i], b_len[i]);
      wait_reads_done();
    end

    // Reads of region A against writes to region B
    fork
      begin
        for (int i = 0; i < N_PAIR; i++) begin
          issue_read(a_addr[i], a_len[i]);
        end
      end
      begin
        for (int i = 0; i < N_CONC; i++) begin
          issue_write(c_addr[i], c_len[i]);
        end
      end
    join
    wait_writes_done();
    wait_reads_done();
    for (int i = 0; i < N_CONC; i++) begin
      issue_read(c_addr[i], c_len[i]);
    end
    wait_reads_done();

    // Engine plus full queue, no stream data yet
    hold_stream = 1'b1;
    for (int i = 0; i < N_FULL; i++) begin
      issue_write(d_addr[i], d_len[i]);
    end
    repeat (16) begin
      @(posedge aclk);
      #2;
      check_equal("wr_req_ready", 32'd0, 32'(wr_req_ready));
    end
    @(posedge aclk);
    hold_stream = 1'b0;
    wait_writes_done();
    for (int i = 0; i < N_FULL; i++) begin
      issue_read(d_addr[i], d_len[i]);
    end
    wait_reads_done();

    // Late extra done pulses would show here
    repeat (8) @(posedge aclk);
    check_equal("rd_done count", rd_issued, rd_done_cnt);
    check_equal("wr_done count", wr_issued, wr_done_cnt);
    check_equal("read words not returned", 32'd0, exp_q.size());
    check_equal("stream words not taken", 32'd0, s_words.size());
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: dv/cdma_asserts.sv
// Concurrent checks on the arbiter grants and the output stream, plus their bind
`timescale 1ns/10ps

module cdma_asserts (
  input logic            aclk,
  input logic            rst_n,
  input logic            rd_gnt,
  input logic            wr_gnt,
  input logic            rd_bus_req,
  input logic            wr_bus_req,
  input logic            rd_beat_valid,
  input logic            wr_beat_valid,
  input cdma_pkg::axis_t m_axis,
  input logic            m_axis_valid,
  input logic            m_axis_ready
);

  ////////////////////////////////////////////////////////////
  // Arbiter
  ////////////////////////////////////////////////////////////

  // One owner of the memory port
  a_one_gnt: assert property (@(posedge aclk) disable iff (!rst_n)
    !(rd_gnt && wr_gnt))
    else $error("rd_gnt and wr_gnt are high in the same cycle");

  // Grant kept for the whole burst
  a_rd_gnt_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    (rd_gnt && rd_bus_req) |=> rd_gnt)
    else $error("rd_gnt dropped while rd_bus_req was still high");

  a_wr_gnt_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    (wr_gnt && wr_bus_req) |=> wr_gnt)
    else $error("wr_gnt dropped while wr_bus_req was still high");

  // Beats only under grant
  a_rd_beat_gnt: assert property (@(posedge aclk) disable iff (!rst_n)
    rd_beat_valid |-> rd_gnt)
    else $error("read beat_valid high without rd_gnt");

  a_wr_beat_gnt: assert property (@(posedge aclk) disable iff (!rst_n)
    wr_beat_valid |-> wr_gnt)
    else $error("write beat_valid high without wr_gnt");

  ////////////////////////////////////////////////////////////
  // Output stream
  ////////////////////////////////////////////////////////////

  // Stalled beat must not change
  a_m_axis_stable: assert property (@(posedge aclk) disable iff (!rst_n)
    (m_axis_valid && !m_axis_ready) |=> (m_axis_valid && $stable(m_axis)))
    else $error("m_axis changed or dropped valid while stalled");

endmodule

// Top level holds both the arbiter wires and m_axis
bind cdma_top cdma_asserts u_cdma_asserts (
  .aclk(aclk), .rst_n(rst_n),
  .rd_gnt(rd_gnt), .wr_gnt(wr_gnt),
  .rd_bus_req(rd_bus_req), .wr_bus_req(wr_bus_req),
  .rd_beat_valid(rd_beat_valid), .wr_beat_valid(wr_beat_valid),
  .m_axis(m_axis), .m_axis_valid(m_axis_valid), .m_axis_ready(m_axis_ready)
);

// File: dv/tb_clock.sv
// Free-running aclk source for the testbench
`timescale 1ns/10ps

module tb_clock #(
  parameter int HALF_NS = 20
) (
  output logic aclk
);

  // 40 ns period
  initial begin
    aclk = 1'b0;
  end

  always #(HALF_NS) aclk = ~aclk;

endmodule

// File: hdl/cdma_top.sv
// DMA subsystem top with request queues, engines, arbiter and memory
`timescale 1ns/10ps
`include "cdma_params.svh"

module cdma_top (
  input  logic               aclk,
  input  logic               rst_n,
  input  cdma_pkg::dma_req_t rd_req,
  input  logic               rd_req_valid,
  output logic               rd_req_ready,
  output logic               rd_done,
  input  cdma_pkg::dma_req_t wr_req,
  input  logic               wr_req_valid,
  output logic               wr_req_ready,
  output logic               wr_done,
  output cdma_pkg::axis_t    m_axis,
  output logic               m_axis_valid,
  input  logic               m_axis_ready,
  input  cdma_pkg::axis_t    s_axis,
  input  logic               s_axis_valid,
  output logic               s_axis_ready
);

  // Queue to engine
  cdma_pkg::dma_req_t rd_q_req;
  logic               rd_q_valid;
  logic               rd_q_ready;
  cdma_pkg::dma_req_t wr_q_req;
  logic               wr_q_valid;
  logic               wr_q_ready;

  // Engine to arbiter
  logic               rd_bus_req;
  logic               rd_gnt;
  cdma_pkg::mem_req_t rd_beat;
  logic               rd_beat_valid;
  logic               wr_bus_req;
  logic               wr_gnt;
  cdma_pkg::mem_req_t wr_beat;
  logic               wr_beat_valid;

  // Memory port and read return
  cdma_pkg::mem_req_t         mem_beat;
  logic                       mem_en;
  logic [`CDMA_DATA_BITS-1:0] mem_rdata;
  logic [`CDMA_DATA_BITS-1:0] rd_rdata;
  logic                       rd_rdata_valid;

  ////////////////////////////////////////////////////////////
  // Request queues
  ////////////////////////////////////////////////////////////

  req_queue u_rd_queue (
    .aclk(aclk), .rst_n(rst_n),
    .in_req(rd_req), .in_valid(rd_req_valid), .in_ready(rd_req_ready),
    .out_req(rd_q_req), .out_valid(rd_q_valid), .out_ready(rd_q_ready)
  );

  req_queue u_wr_queue (
    .aclk(aclk), .rst_n(rst_n),
    .in_req(wr_req), .in_valid(wr_req_valid), .in_ready(wr_req_ready),
    .out_req(wr_q_req), .out_valid(wr_q_valid), .out_ready(wr_q_ready)
  );

  ////////////////////////////////////////////////////////////
  // Engines, arbiter, memory
  ////////////////////////////////////////////////////////////

  dma_rd_engine u_rd_engine (
    .aclk(aclk), .rst_n(rst_n),
    .req(rd_q_req), .req_valid(rd_q_valid), .req_ready(rd_q_ready),
    .bus_req(rd_bus_req), .gnt(rd_gnt), .beat(rd_beat), .beat_valid(rd_beat_valid),
    .rdata(rd_rdata), .rdata_valid(rd_rdata_valid),
    .m_axis(m_axis), .m_axis_valid(m_axis_valid), .m_axis_ready(m_axis_ready),
    .done(rd_done)
  );

  dma_wr_engine u_wr_engine (
    .aclk(aclk), .rst_n(rst_n),
    .req(wr_q_req), .req_valid(wr_q_valid), .req_ready(wr_q_ready),
    .bus_req(wr_bus_req), .gnt(wr_gnt), .beat(wr_beat), .beat_valid(wr_beat_valid),
    .s_axis(s_axis), .s_axis_valid(s_axis_valid), .s_axis_ready(s_axis_ready),
    .done(wr_done)
  );

  mem_arbiter u_mem_arbiter (
    .aclk(aclk), .rst_n(rst_n),
    .rd_bus_req(rd_bus_req), .rd_beat(rd_beat), .rd_beat_valid(rd_beat_valid),
    .rd_gnt(rd_gnt),
    .wr_bus_req(wr_bus_req), .wr_beat(wr_beat), .wr_beat_valid(wr_beat_valid),
    .wr_gnt(wr_gnt),
    .mem_beat(mem_beat), .mem_en(mem_en), .mem_rdata(mem_rdata),
    .rd_rdata(rd_rdata), .rd_rdata_valid(rd_rdata_valid)
  );

  burst_mem u_burst_mem (
    .aclk(aclk), .beat(mem_beat), .en(mem_en), .rdata(mem_rdata)
  );

endmodule

// File: hdl/burst_mem.sv
// Single-port word memory with registered read data
`timescale 1ns/10ps
`include "cdma_params.svh"

module burst_mem (
  input  logic                       aclk,
  input  cdma_pkg::mem_req_t         beat,
  input  logic                       en,
  output logic [`CDMA_DATA_BITS-1:0] rdata
);

  logic [`CDMA_DATA_BITS-1:0] mem [`CDMA_MEM_WORDS];

  // Write or read, never both
  // read data valid one cycle later
  always_ff @(posedge aclk) begin
    if (en) begin
      if (beat.op == cdma_pkg::MEM_WR) begin
        mem[beat.addr] <= beat.wdata;
      end else begin
        rdata <= mem[beat.addr];
      end
    end
  end

endmodule

// File: hdl/mem_arbiter.sv
// Round-robin arbiter for the shared memory port with read data return
`timescale 1ns/10ps
`include "cdma_params.svh"

module mem_arbiter (
  input  logic                       aclk,
  input  logic                       rst_n,
  input  logic                       rd_bus_req,
  input  cdma_pkg::mem_req_t         rd_beat,
  input  logic                       rd_beat_valid,
  output logic                       rd_gnt,
  input  logic                       wr_bus_req,
  input  cdma_pkg::mem_req_t         wr_beat,
  input  logic                       wr_beat_valid,
  output logic                       wr_gnt,
  output cdma_pkg::mem_req_t         mem_beat,
  output logic                       mem_en,
  input  logic [`CDMA_DATA_BITS-1:0] mem_rdata,
  output logic [`CDMA_DATA_BITS-1:0] rd_rdata,
  output logic                       rd_rdata_valid
);

  // Set when the write engine won last
  logic last_wr;

  ////////////////////////////////////////////////////////////
  // Grant, held for a whole burst
  ////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      rd_gnt  <= 1'b0;
      wr_gnt  <= 1'b0;
      last_wr <= 1'b0;
    end else if (rd_gnt) begin
      rd_gnt <= rd_bus_req;
    end else if (wr_gnt) begin
      wr_gnt <= wr_bus_req;
    end else if (rd_bus_req && (!wr_bus_req || last_wr)) begin
      // Idle cycle between grants lands here
      rd_gnt  <= 1'b1;
      last_wr <= 1'b0;
    end else if (wr_bus_req) begin
      wr_gnt  <= 1'b1;
      last_wr <= 1'b1;
    end
  end

  // Beat mux onto memory
  assign mem_beat = rd_gnt ? rd_beat : wr_beat;
  assign mem_en   = (rd_gnt && rd_beat_valid) || (wr_gnt && wr_beat_valid);

  // Read data one cycle behind its beat
  assign rd_rdata = mem_rdata;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      rd_rdata_valid <= 1'b0;
    end else begin
      rd_rdata_valid <= rd_gnt && rd_beat_valid && (rd_beat.op == cdma_pkg::MEM_RD);
    end
  end

endmodule

// File: hdl/dma_wr_engine.sv
// Write DMA engine, burst splitting and stream to memory writes
`timescale 1ns/10ps
`include "cdma_params.svh"

module dma_wr_engine (
  input  logic               aclk,
  input  logic               rst_n,
  input  cdma_pkg::dma_req_t req,
  input  logic               req_valid,
  output logic               req_ready,
  output logic               bus_req,
  input  logic               gnt,
  output cdma_pkg::mem_req_t beat,
  output logic               beat_valid,
  input  cdma_pkg::axis_t    s_axis,
  input  logic               s_axis_valid,
  output logic               s_axis_ready,
  output logic               done
);

  localparam int BW = $clog2(`CDMA_BURST_LEN + 1);

  cdma_pkg::eng_state_e       state;
  logic [`CDMA_ADDR_BITS-1:0] cur_addr;
  logic [`CDMA_LEN_BITS-1:0]  words_left;
  logic [BW-1:0]              burst_left;
  logic                       last_beat;

  assign req_ready = (state == cdma_pkg::ST_IDLE);

  // Accept stream words only while owning the bus
  assign s_axis_ready = (state == cdma_pkg::ST_BURST) && gnt;
  assign beat_valid   = s_axis_ready && s_axis_valid;
  assign last_beat    = (burst_left == BW'(1));

  // Grant kept through input gaps
  assign bus_req = (state == cdma_pkg::ST_REQ) ||
                   ((state == cdma_pkg::ST_BURST) && !(beat_valid && last_beat));

  // Each stream word is one write beat
  // tlast ignored, request length ends the transfer
  assign beat.op    = cdma_pkg::MEM_WR;
  assign beat.addr  = cur_addr;
  assign beat.wdata = s_axis.tdata;

  ////////////////////////////////////////////////////////////
  // Burst FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      state <= cdma_pkg::ST_IDLE;
      done  <= 1'b0;
    end else begin
      // Final word written at this edge
      done <= beat_valid && (words_left == `CDMA_LEN_BITS'(1));
      case (state)
        cdma_pkg::ST_IDLE: begin
          if (req_valid) begin
            cur_addr   <= req.addr;
            words_left <= req.len;
            state      <= cdma_pkg::ST_REQ;
          end
        end
        cdma_pkg::ST_REQ: begin
          if (gnt) begin
            burst_left <= (words_left > `CDMA_LEN_BITS'(`CDMA_BURST_LEN)) ?
                          BW'(`CDMA_BURST_LEN) : BW'(words_left);
            state      <= cdma_pkg::ST_BURST;
          end
        end
        cdma_pkg::ST_BURST: begin
          if (beat_valid) begin
            cur_addr   <= cur_addr + `CDMA_ADDR_BITS'(1);
            words_left <= words_left - `CDMA_LEN_BITS'(1);
            burst_left <= burst_left - BW'(1);
            // Next burst or done
            if (last_beat) begin
              state <= (words_left == `CDMA_LEN_BITS'(1)) ? cdma_pkg::ST_IDLE
                                                           : cdma_pkg::ST_REQ;
            end
          end
        end
        default: state <= cdma_pkg::ST_IDLE;
      endcase
    end
  end

endmodule

// File: hdl/dma_rd_engine.sv
// Read DMA engine, burst splitting and two-entry output stream buffer
`timescale 1ns/10ps
`include "cdma_params.svh"

module dma_rd_engine (
  input  logic                       aclk,
  input  logic                       rst_n,
  input  cdma_pkg::dma_req_t         req,
  input  logic                       req_valid,
  output logic                       req_ready,
  output logic                       bus_req,
  input  logic                       gnt,
  output cdma_pkg::mem_req_t         beat,
  output logic                       beat_valid,
  input  logic [`CDMA_DATA_BITS-1:0] rdata,
  input  logic                       rdata_valid,
  output cdma_pkg::axis_t            m_axis,
  output logic                       m_axis_valid,
  input  logic                       m_axis_ready,
  output logic                       done
);

  localparam int BW = $clog2(`CDMA_BURST_LEN + 1);

  cdma_pkg::eng_state_e       state;
  logic [`CDMA_ADDR_BITS-1:0] cur_addr;
  logic [`CDMA_LEN_BITS-1:0]  words_left;
  logic [BW-1:0]              burst_left;
  logic                       last_in_flight;
  cdma_pkg::axis_t            obuf [2];
  logic                       obuf_wr;
  logic                       obuf_rd;
  logic [1:0]                 obuf_cnt;
  logic                       pop;
  logic                       room;
  logic                       last_beat;

  ////////////////////////////////////////////////////////////
  // Memory side
  ////////////////////////////////////////////////////////////

  assign req_ready = (state == cdma_pkg::ST_IDLE);
  assign pop       = m_axis_valid && m_axis_ready;

  // Free slot, word in flight counts as taken
  assign room = ({1'b0, obuf_cnt} + {2'b0, rdata_valid}) < ({2'b0, pop} + 3'd2);

  assign beat_valid = (state == cdma_pkg::ST_BURST) && gnt && room;
  assign last_beat  = (burst_left == BW'(1));

  // Bus released together with the last beat
  assign bus_req = (state == cdma_pkg::ST_REQ) ||
                   ((state == cdma_pkg::ST_BURST) && !(beat_valid && last_beat));

  assign beat.op    = cdma_pkg::MEM_RD;
  assign beat.addr  = cur_addr;
  assign beat.wdata = '0;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      state          <= cdma_pkg::ST_IDLE;
      last_in_flight <= 1'b0;
    end else begin
      // Marks the word returning next cycle as final
      last_in_flight <= beat_valid && (words_left == `CDMA_LEN_BITS'(1));
      case (state)
        cdma_pkg::ST_IDLE: begin
          if (req_valid) begin
            cur_addr   <= req.addr;
            words_left <= req.len;
            state      <= cdma_pkg::ST_REQ;
          end
        end
        cdma_pkg::ST_REQ: begin
          // Burst is the rest of the request, capped
          if (gnt) begin
            burst_left <= (words_left > `CDMA_LEN_BITS'(`CDMA_BURST_LEN)) ?
                          BW'(`CDMA_BURST_LEN) : BW'(words_left);
            state      <= cdma_pkg::ST_BURST;
          end
        end
        cdma_pkg::ST_BURST: begin
          if (beat_valid) begin
            cur_addr   <= cur_addr + `CDMA_ADDR_BITS'(1);
            words_left <= words_left - `CDMA_LEN_BITS'(1);
            burst_left <= burst_left - BW'(1);
            if (last_beat) begin
              state <= (words_left == `CDMA_LEN_BITS'(1)) ? cdma_pkg::ST_IDLE
                                                           : cdma_pkg::ST_REQ;
            end
          end
        end
        default: state <= cdma_pkg::ST_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Stream side
  ////////////////////////////////////////////////////////////

  assign m_axis_valid = (obuf_cnt != 2'd0);
  assign m_axis       = obuf[obuf_rd];

  // Buffer payload
  always_ff @(posedge aclk) begin
    if (rdata_valid) begin
      obuf[obuf_wr].tdata <= rdata;
      obuf[obuf_wr].tlast <= last_in_flight;
    end
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      obuf_wr  <= 1'b0;
      obuf_rd  <= 1'b0;
      obuf_cnt <= 2'd0;
      done     <= 1'b0;
    end else begin
      if (rdata_valid) begin
        obuf_wr <= ~obuf_wr;
      end
      if (pop) begin
        obuf_rd <= ~obuf_rd;
      end
      obuf_cnt <= obuf_cnt + {1'b0, rdata_valid} - {1'b0, pop};
      // Pulse after final word leaves
      done     <= pop && m_axis.tlast;
    end
  end

endmodule

// File: hdl/req_queue.sv
// Request FIFO with valid/ready on both sides
`timescale 1ns/10ps
`include "cdma_params.svh"

module req_queue (
  input  logic               aclk,
  input  logic               rst_n,
  input  cdma_pkg::dma_req_t in_req,
  input  logic               in_valid,
  output logic               in_ready,
  output cdma_pkg::dma_req_t out_req,
  output logic               out_valid,
  input  logic               out_ready
);

  localparam int PW = $clog2(`CDMA_QDEPTH);
  localparam int CW = $clog2(`CDMA_QDEPTH + 1);

  cdma_pkg::dma_req_t entries [`CDMA_QDEPTH];
  logic [PW-1:0]      wr_ptr;
  logic [PW-1:0]      rd_ptr;
  logic [CW-1:0]      count;
  logic               push;
  logic               pop;

  // Ready drops only when full
  assign in_ready  = (count != CW'(`CDMA_QDEPTH));
  assign out_valid = (count != '0);
  assign out_req   = entries[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // Storage
  always_ff @(posedge aclk) begin
    if (push) begin
      entries[wr_ptr] <= in_req;
    end
  end

  // Pointers wrap, depth is a power of two
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + PW'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + PW'(1);
      end
      count <= count + CW'(push) - CW'(pop);
    end
  end

endmodule

// File: hdl/cdma_pkg.sv
// Request, memory beat and stream structs, memory opcode and engine state enums
`include "cdma_params.svh"

package cdma_pkg;

  ////////////////////////////////////////////////////////////
  // Requests
  ////////////////////////////////////////////////////////////

  // DMA request, start word address and length in words
  typedef struct packed {
    logic [`CDMA_ADDR_BITS-1:0] addr;
    logic [`CDMA_LEN_BITS-1:0]  len;
  } dma_req_t;

  ////////////////////////////////////////////////////////////
  // Memory port
  ////////////////////////////////////////////////////////////

  typedef enum logic {
    MEM_RD,
    MEM_WR
  } mem_op_e;

  // One memory beat
  typedef struct packed {
    mem_op_e                    op;
    logic [`CDMA_ADDR_BITS-1:0] addr;
    logic [`CDMA_DATA_BITS-1:0] wdata;
  } mem_req_t;

  // One stream beat
  typedef struct packed {
    logic [`CDMA_DATA_BITS-1:0] tdata;
    logic                       tlast;
  } axis_t;

  // Engine FSM, ST_REQ waits for the grant
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_BURST
  } eng_state_e;

endpackage

// File: include/cdma_params.svh
// Width, burst length, queue depth and memory depth macros
`ifndef CDMA_PARAMS_SVH
`define CDMA_PARAMS_SVH

// Stream and memory word width
`define CDMA_DATA_BITS 32

// Word address width
`define CDMA_ADDR_BITS 10

// Request length in words, 1 to 255
`define CDMA_LEN_BITS 8

// Most beats per arbitration grant
`define CDMA_BURST_LEN 8

// Entries in each request queue
`define CDMA_QDEPTH 4

// Memory depth in words
`define CDMA_MEM_WORDS 1024

`endif
